// ==== source/bus_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decoder: region select, strobe routing
// and response multiplexing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "soc_consts.svh"

module bus_decoder (
  input  logic               i_pad_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_bus,
  output soc_pkg::wb_rsp_t   o_bus,
  output soc_pkg::wb_req_t   o_sram_req,
  output soc_pkg::wb_req_t   o_gpio_req,
  output soc_pkg::wb_req_t   o_err_req,
  input  soc_pkg::wb_rsp_t   i_sram_rsp,
  input  soc_pkg::wb_rsp_t   i_gpio_rsp,
  input  soc_pkg::wb_rsp_t   i_err_rsp
);

  soc_pkg::region_e region;
  logic [`REGION_MSB-`REGION_LSB:0] region_field;

  assign region_field = i_bus.adr[`REGION_MSB:`REGION_LSB];

  always_comb begin
    case (region_field)
      `REGION_SRAM: region = soc_pkg::REG_SRAM;
      `REGION_GPIO: region = soc_pkg::REG_GPIO;
      default:      region = soc_pkg::REG_NONE;
    endcase
  end

  // every slave sees the full request, only the selected one keeps stb
  always_comb begin
    o_sram_req     = i_bus;
    o_gpio_req     = i_bus;
    o_err_req      = i_bus;
    o_sram_req.stb = i_bus.stb && (region == soc_pkg::REG_SRAM);
    o_gpio_req.stb = i_bus.stb && (region == soc_pkg::REG_GPIO);
    o_err_req.stb  = i_bus.stb && (region == soc_pkg::REG_NONE);
  end

  // adr is held until the response, so the same region picks it
  always_comb begin
    case (region)
      soc_pkg::REG_SRAM: o_bus = i_sram_rsp;
      soc_pkg::REG_GPIO: o_bus = i_gpio_rsp;
      default:           o_bus = i_err_rsp;
    endcase
  end

  logic sram_busy;
  logic gpio_busy;
  logic err_busy;

  assign sram_busy = i_sram_rsp.ack || i_sram_rsp.err;
  assign gpio_busy = i_gpio_rsp.ack || i_gpio_rsp.err;
  assign err_busy  = i_err_rsp.ack || i_err_rsp.err;

  // only one slave may answer at a time
  a_one_responder: assert property (
    @(posedge i_pad_clk) disable iff (!i_arst_n)
    $onehot0({sram_busy, gpio_busy, err_busy})
  );

endmodule

// ==== source/err_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// error slave for unmapped regions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module err_slave (
  input  logic               i_pad_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_req,
  output soc_pkg::wb_rsp_t   o_rsp
);

  logic err_q;
  logic access;

  assign access = i_req.cyc && i_req.stb && !err_q;

  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= access;
    end
  end

  // never acks, data always zero
  assign o_rsp.ack = 1'b0;
  assign o_rsp.err = err_q;
  assign o_rsp.dat = '0;

endmodule

// ==== source/gpio_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO slave: out and dir registers, two-flop
// input synchronizer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "soc_consts.svh"

module gpio_slave (
  input  logic               i_pad_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_req,
  output soc_pkg::wb_rsp_t   o_rsp,
  input  soc_pkg::gpio_t     i_gpio_in,
  output soc_pkg::gpio_t     o_gpio_out,
  output soc_pkg::gpio_t     o_gpio_oe
);

  // word offset inside the region
  localparam int unsigned OFS_W = `REGION_LSB - 2;
  typedef logic [OFS_W-1:0] ofs_t;

  soc_pkg::gpio_t out_q;
  soc_pkg::gpio_t dir_q;
  soc_pkg::gpio_t sync1_q;
  soc_pkg::gpio_t sync2_q;
  soc_pkg::bus_data_t rdata_q;
  ofs_t ofs;
  logic ack_q;
  logic access;
  logic wr_lane0;

  assign ofs      = i_req.adr[`REGION_LSB-1:2];
  assign access   = i_req.cyc && i_req.stb && !ack_q;
  assign wr_lane0 = access && i_req.we && i_req.sel[0];

  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      dir_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      ack_q   <= access;
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      if (wr_lane0 && ofs == ofs_t'(`GPIO_OFS_OUT)) begin
        out_q <= i_req.dat[`GPIO_W-1:0];
      end
      if (wr_lane0 && ofs == ofs_t'(`GPIO_OFS_DIR)) begin
        dir_q <= i_req.dat[`GPIO_W-1:0];
      end
    end
  end

  // readback, zero-extended; unknown offsets read zero
  always_ff @(posedge i_pad_clk) begin
    if (access) begin
      rdata_q <= '0;
      if (!i_req.we) begin
        case (ofs)
          ofs_t'(`GPIO_OFS_OUT): rdata_q <= soc_pkg::bus_data_t'(out_q);
          ofs_t'(`GPIO_OFS_DIR): rdata_q <= soc_pkg::bus_data_t'(dir_q);
          ofs_t'(`GPIO_OFS_IN):  rdata_q <= soc_pkg::bus_data_t'(sync2_q);
          default:               rdata_q <= '0;
        endcase
      end
    end
  end

  assign o_rsp.ack  = ack_q;
  assign o_rsp.err  = 1'b0;
  assign o_rsp.dat  = rdata_q;
  assign o_gpio_out = out_q;
  assign o_gpio_oe  = dir_q;

endmodule

// ==== source/soc_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths, SRAM size, GPIO pin count and the
// address map of the tiny SoC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

`define SOC_ADDR_W 24
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// 256 words
`define SRAM_IDX_W 8

// region field of the byte address
`define REGION_MSB 23
`define REGION_LSB 20
`define REGION_SRAM 4'h0
`define REGION_GPIO 4'h1

`define GPIO_W 8
// word offsets inside the GPIO region
`define GPIO_OFS_OUT 0
`define GPIO_OFS_DIR 1
`define GPIO_OFS_IN 2

`endif

// ==== source/soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus types, Wishbone request/response structs
// and the region enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_consts.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
  typedef logic [`SOC_DATA_W-1:0] bus_data_t;
  typedef logic [`SOC_SEL_W-1:0] bus_sel_t;
  typedef logic [`GPIO_W-1:0] gpio_t;

  // master to slave
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    bus_addr_t adr;
    bus_data_t dat;
    bus_sel_t sel;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic ack;
    logic err;
    bus_data_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    REG_SRAM,
    REG_GPIO,
    REG_NONE
  } region_e;

endpackage

// ==== source/sram_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-addressed SRAM slave with byte-lane writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "soc_consts.svh"

module sram_slave (
  input  logic               i_pad_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_req,
  output soc_pkg::wb_rsp_t   o_rsp
);

  localparam int unsigned DEPTH = 1 << `SRAM_IDX_W;

  soc_pkg::bus_data_t mem [DEPTH];
  soc_pkg::bus_data_t rdata_q;
  logic [`SRAM_IDX_W-1:0] idx;
  logic ack_q;
  logic access;

  assign idx = i_req.adr[`SRAM_IDX_W+1:2];

  // new access only when no ack went out last cycle
  assign access = i_req.cyc && i_req.stb && !ack_q;

  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // byte lanes
  always_ff @(posedge i_pad_clk) begin
    if (access && i_req.we) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (i_req.sel[b]) begin
          mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
        end
      end
    end
  end

  // write acks return zero data
  always_ff @(posedge i_pad_clk) begin
    if (access) begin
      rdata_q <= i_req.we ? '0 : mem[idx];
    end
  end

  assign o_rsp.ack = ack_q;
  assign o_rsp.err = 1'b0;
  assign o_rsp.dat = rdata_q;

endmodule

// ==== source/tiny_soc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level: decoder plus SRAM, GPIO and error
// slaves on one Wishbone classic bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tiny_soc (
  input  logic               i_pad_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_bus,
  output soc_pkg::wb_rsp_t   o_bus,
  input  soc_pkg::gpio_t     i_gpio_in,
  output soc_pkg::gpio_t     o_gpio_out,
  output soc_pkg::gpio_t     o_gpio_oe
);

  soc_pkg::wb_req_t sram_req;
  soc_pkg::wb_req_t gpio_req;
  soc_pkg::wb_req_t err_req;
  soc_pkg::wb_rsp_t sram_rsp;
  soc_pkg::wb_rsp_t gpio_rsp;
  soc_pkg::wb_rsp_t err_rsp;

  bus_decoder x_bus_decoder (
    .i_pad_clk  (i_pad_clk),
    .i_arst_n   (i_arst_n),
    .i_bus      (i_bus),
    .o_bus      (o_bus),
    .o_sram_req (sram_req),
    .o_gpio_req (gpio_req),
    .o_err_req  (err_req),
    .i_sram_rsp (sram_rsp),
    .i_gpio_rsp (gpio_rsp),
    .i_err_rsp  (err_rsp)
  );

  sram_slave x_sram_slave (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .i_req     (sram_req),
    .o_rsp     (sram_rsp)
  );

  gpio_slave x_gpio_slave (
    .i_pad_clk  (i_pad_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (gpio_req),
    .o_rsp      (gpio_rsp),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe)
  );

  // catches everything outside the SRAM and GPIO regions
  err_slave x_err_slave (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .i_req     (err_req),
    .o_rsp     (err_rsp)
  );

endmodule

// ==== verif/bus_stimulus.txt ====
# name op(W/R) addr data sel gpio_in exp_data exp_rsp(A/E) exp_gpio_out exp_gpio_oe
# hex fields; exp_gpio_out and exp_gpio_oe are the pin values once the access completes
sram_wr0     W 000000 11223344 f 00 00000000 A 00 00
sram_wr1     W 000004 a5a5a5a5 f 00 00000000 A 00 00
sram_wr2     W 0003fc deadbeef f 00 00000000 A 00 00
sram_rd0     R 000000 00000000 f 00 11223344 A 00 00
sram_rd1     R 000004 00000000 f 00 a5a5a5a5 A 00 00
sram_rd2     R 0003fc 00000000 f 00 deadbeef A 00 00
lane_wr0     W 000000 99aabbcc 5 00 00000000 A 00 00
lane_rd0     R 000000 00000000 f 00 11aa33cc A 00 00
lane_wr1     W 000004 12345678 8 00 00000000 A 00 00
lane_rd1     R 000004 00000000 f 00 12a5a5a5 A 00 00
lane_wr2     W 0003fc 0000ff11 3 00 00000000 A 00 00
lane_rd2     R 0003fc 00000000 f 00 deadff11 A 00 00
gpio_out_wr  W 100000 ffffff5a 1 00 00000000 A 5a 00
gpio_dir_wr  W 100004 000000f0 1 00 00000000 A 5a f0
gpio_out_rd  R 100000 00000000 f 00 0000005a A 5a f0
gpio_dir_rd  R 100004 00000000 f 00 000000f0 A 5a f0
gpio_nolane  W 100000 0000ff00 2 00 00000000 A 5a f0
gpio_out_rd2 R 100000 00000000 f 00 0000005a A 5a f0
gpio_in_rd   R 100008 00000000 f 3c 0000003c A 5a f0
gpio_in_rd2  R 100008 00000000 f c3 000000c3 A 5a f0
gpio_in_wr   W 100008 000000ff 1 c3 00000000 A 5a f0
gpio_in_rd3  R 100008 00000000 f c3 000000c3 A 5a f0
gpio_ofs_rd  R 10000c 00000000 f c3 00000000 A 5a f0
unmap_rd     R 200000 00000000 f c3 00000000 E 5a f0
unmap_wr     W f00010 12345678 f c3 00000000 E 5a f0
unmap_rd2    R 3000fc 00000000 f c3 00000000 E 5a f0
sram_after0  R 000000 00000000 f c3 11aa33cc A 5a f0
sram_after1  R 000004 00000000 f c3 12a5a5a5 A 5a f0

// ==== verif/tb_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response checker: reset values, response kind,
// read data, GPIO outputs and response timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_checker (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  soc_pkg::wb_req_t   i_bus,
  input  soc_pkg::wb_rsp_t   i_rsp,
  input  soc_pkg::gpio_t     i_gpio_out,
  input  soc_pkg::gpio_t     i_gpio_oe,
  input  logic [8*16-1:0]    i_test,
  input  soc_pkg::bus_data_t i_exp_dat,
  input  logic               i_exp_err,
  input  soc_pkg::gpio_t     i_exp_out,
  input  soc_pkg::gpio_t     i_exp_oe,
  output int                 o_value_errs,
  output int                 o_protocol_errs
);

  logic pending;
  int   age;

  initial begin
    o_value_errs    = 0;
    o_protocol_errs = 0;
    pending         = 1'b0;
    age             = 0;
  end

  function automatic string kind_name(input logic ack, input logic err);
    if (ack && err) begin
      return "ack+err";
    end
    if (ack) begin
      return "ack";
    end
    return err ? "err" : "none";
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      o_value_errs++;
      $display("ERROR %0s expected %0s=%h actual %0s=%h", i_test, what, exp, what, act);
    end
  endtask

  task automatic check_response();
    string exp_kind;
    string act_kind;
    exp_kind = i_exp_err ? "err" : "ack";
    act_kind = kind_name(i_rsp.ack, i_rsp.err);
    if (exp_kind != act_kind) begin
      o_value_errs++;
      $display("ERROR %0s expected %0s actual %0s", i_test, exp_kind, act_kind);
    end
    compare_value("dat", i_exp_dat, i_rsp.dat);
    // a write has already landed on the pins by now
    compare_value("gpio_out", 32'(i_exp_out), 32'(i_gpio_out));
    compare_value("gpio_oe", 32'(i_exp_oe), 32'(i_gpio_oe));
    if (age != 0) begin
      o_protocol_errs++;
      $display("Response in test %0s came %0d cycles too late.", i_test, age);
    end
  endtask

  // sampled at the edge, before any update of that edge lands
  always @(posedge i_clk) begin
    if (!i_arst_n) begin
      pending = 1'b0;
      age     = 0;
      if (i_rsp.ack || i_rsp.err || i_gpio_out != '0 || i_gpio_oe != '0) begin
        o_protocol_errs++;
        $display("DUT outputs left their reset values while reset was asserted.");
      end
    end else if (i_rsp.ack || i_rsp.err) begin
      if (!pending) begin
        o_protocol_errs++;
        $display("DUT gave a response with no access pending, after test %0s.", i_test);
      end else begin
        check_response();
      end
      pending = 1'b0;
    end else if (pending) begin
      age++;
    end else if (i_bus.cyc && i_bus.stb) begin
      // first edge with stb high, answer due at the next one
      pending = 1'b1;
      age     = 0;
    end
  end

endmodule

// ==== verif/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 8 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock (
  output logic o_clk
);

  localparam realtime HALF_PERIOD = 4.0;

  initial begin
    o_clk = 1'b0;
  end

  always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// ==== verif/tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top: bus master driven from the
// stimulus file, clock, checker and the DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_top;

  localparam int RSP_TIMEOUT = 20;

  logic               clk;
  logic               arst_n;
  soc_pkg::wb_req_t   bus_req;
  soc_pkg::wb_rsp_t   bus_rsp;
  soc_pkg::gpio_t     gpio_in;
  soc_pkg::gpio_t     gpio_out;
  soc_pkg::gpio_t     gpio_oe;
  logic [8*16-1:0]    exp_test;
  soc_pkg::bus_data_t exp_dat;
  logic               exp_err;
  soc_pkg::gpio_t     exp_out;
  soc_pkg::gpio_t     exp_oe;
  int                 value_errs;
  int                 protocol_errs;
  int                 timeouts;
  int                 seed;
  bit                 aborted;

  tb_clock x_clock (
    .o_clk (clk)
  );

  tiny_soc UUT (
    .i_pad_clk  (clk),
    .i_arst_n   (arst_n),
    .i_bus      (bus_req),
    .o_bus      (bus_rsp),
    .i_gpio_in  (gpio_in),
    .o_gpio_out (gpio_out),
    .o_gpio_oe  (gpio_oe)
  );

  tb_checker x_checker (
    .i_clk           (clk),
    .i_arst_n        (arst_n),
    .i_bus           (bus_req),
    .i_rsp           (bus_rsp),
    .i_gpio_out      (gpio_out),
    .i_gpio_oe       (gpio_oe),
    .i_test          (exp_test),
    .i_exp_dat       (exp_dat),
    .i_exp_err       (exp_err),
    .i_exp_out       (exp_out),
    .i_exp_oe        (exp_oe),
    .o_value_errs    (value_errs),
    .o_protocol_errs (protocol_errs)
  );

  // called on a rising edge, returns after the response edge
  task automatic run_access(input logic is_write, input soc_pkg::bus_addr_t adr,
                            input soc_pkg::bus_data_t dat, input soc_pkg::bus_sel_t sel,
                            output bit got_rsp);
    int cycles;
    cycles  = 0;
    got_rsp = 1'b0;
    bus_req.cyc <= 1'b1;
    bus_req.stb <= 1'b1;
    bus_req.we  <= is_write;
    bus_req.adr <= adr;
    bus_req.dat <= dat;
    bus_req.sel <= sel;
    while (!got_rsp && cycles < RSP_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      got_rsp = bus_rsp.ack || bus_rsp.err;
    end
    bus_req.cyc <= 1'b0;
    bus_req.stb <= 1'b0;
  endtask

  task automatic finish_run(input bit failed);
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errs, protocol_errs, timeouts);
    if (failed || value_errs != 0 || protocol_errs != 0 || timeouts != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  endtask

  initial begin
    string              line;
    int                 fd;
    int                 n_read;
    int                 n_fields;
    bit                 got;
    logic [8*16-1:0]    name;
    logic [7:0]         op;
    logic [7:0]         rsp;
    soc_pkg::bus_addr_t adr;
    soc_pkg::bus_data_t dat;
    soc_pkg::bus_sel_t  sel;
    soc_pkg::gpio_t     gin;
    soc_pkg::bus_data_t edat;
    soc_pkg::gpio_t     eout;
    soc_pkg::gpio_t     eoe;
    seed     = 32'h8fc1_a66f;
    aborted  = 1'b0;
    timeouts = 0;
    arst_n   = 1'b0;
    bus_req  = '0;
    gpio_in  = '0;
    exp_test = '0;
    exp_dat  = '0;
    exp_err  = 1'b0;
    exp_out  = '0;
    exp_oe   = '0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    fd = $fopen("verif/bus_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verif/bus_stimulus.txt.");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      n_read   = $fgets(line, fd);
      n_fields = $sscanf(line, "%s %s %h %h %h %h %h %s %h %h",
                         name, op, adr, dat, sel, gin, edat, rsp, eout, eoe);
      if (n_read > 0 && line.getc(0) != "#" && n_fields == 10) begin
        @(posedge clk);
        gpio_in <= gin;
        // two edges so the synchronizer holds the new pins
        repeat (2) @(posedge clk);
        exp_test <= name;
        exp_dat  <= edat;
        exp_err  <= (rsp == "E");
        exp_out  <= eout;
        exp_oe   <= eoe;
        run_access(op == "W", adr, dat, sel, got);
        if (!got) begin
          $display("No response from the DUT within %0d cycles in test %0s.",
                   RSP_TIMEOUT, name);
          timeouts++;
          aborted = 1'b1;
        end else begin
          repeat ($unsigned($random(seed)) % 4) @(posedge clk);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    finish_run(aborted);
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/soc_pkg.sv
source/bus_decoder.sv
source/sram_slave.sv
source/gpio_slave.sv
source/err_slave.sv
source/tiny_soc.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv
